/* include/alu_tb_ref.svh */
`ifndef ALU_TB_REF_SVH
`define ALU_TB_REF_SVH

// model of A to D plus CARRY
typedef struct packed {
  logic [3:0][63:0] r;
  logic             carry;
} alu_state_t;

alu_state_t ref_mirror;

function automatic logic [31:0] ref_half(alu_state_t s, logic [1:0] sel, logic half);
  return s.r[sel][half*32 +: 32];
endfunction

// codes 4 and 5 give the immediate and zero
function automatic logic [3:0] source_nibble(alu_state_t s, logic [2:0] sel,
                                             logic [3:0] imm, logic [3:0] idx);
  if (sel == alu_pkg::SRC_IMM)
    return imm;
  if (sel == alu_pkg::SRC_ZERO)
    return 4'h0;
  return s.r[sel[1:0]][idx*4 +: 4];
endfunction

// field digit k sits at bits 4k of va, vb and res
function automatic alu_state_t alu_ref(alu_state_t s, logic [31:0] cmd);
  alu_state_t       n;
  alu_pkg::alu_op_t op;
  logic [1:0]       dest;
  logic [2:0]       src1;
  logic [2:0]       src2;
  logic [3:0]       first;
  logic [3:0]       last;
  logic [3:0]       imm;
  logic [3:0]       idx;
  logic [63:0]      va;
  logic [63:0]      vb;
  logic [63:0]      res;
  logic [64:0]      sum;
  logic             is_test;
  int               cnt;
  n     = s;
  op    = alu_pkg::alu_op_t'(cmd[alu_pkg::CMD_OP_LSB +: alu_pkg::CMD_OP_W]);
  dest  = cmd[alu_pkg::CMD_DEST_LSB +: alu_pkg::CMD_DEST_W];
  src1  = cmd[alu_pkg::CMD_SRC1_LSB +: alu_pkg::CMD_SRC1_W];
  src2  = cmd[alu_pkg::CMD_SRC2_LSB +: alu_pkg::CMD_SRC2_W];
  first = cmd[alu_pkg::CMD_START_LSB +: alu_pkg::CMD_START_W];
  last  = cmd[alu_pkg::CMD_LAST_LSB +: alu_pkg::CMD_LAST_W];
  imm   = cmd[alu_pkg::CMD_IMM_LSB +: alu_pkg::CMD_IMM_W];
  // field length wraps modulo 16
  cnt   = int'(4'(last - first)) + 1;
  va    = '0;
  vb    = '0;
  for (int k = 0; k < cnt; k++) begin
    idx = 4'(first + k);
    va[4*k +: 4] = source_nibble(s, src1, imm, idx);
    vb[4*k +: 4] = source_nibble(s, src2, imm, idx);
  end
  sum     = {1'b0, va} + {1'b0, vb};
  is_test = (op == alu_pkg::OP_TEST_EQ) || (op == alu_pkg::OP_TEST_NEQ);
  res     = va;
  case (op)
    alu_pkg::OP_ZERO:     res = '0;
    alu_pkg::OP_EXCH:     res = vb;
    alu_pkg::OP_ADD: begin
      res     = sum[63:0];
      // carry out of the top field digit
      n.carry = sum[4*cnt];
    end
    alu_pkg::OP_2CMPL: begin
      res     = -va;
      n.carry = (va != '0);
    end
    alu_pkg::OP_CLR_MASK: res = va & ~vb;
    alu_pkg::OP_TEST_EQ:  n.carry = (va == vb);
    alu_pkg::OP_TEST_NEQ: n.carry = (va != vb);
    default: ;
  endcase
  for (int k = 0; k < cnt; k++) begin
    idx = 4'(first + k);
    if (!is_test)
      n.r[dest][idx*4 +: 4] = res[4*k +: 4];
    if (op == alu_pkg::OP_EXCH && !src2[2])
      n.r[src2[1:0]][idx*4 +: 4] = va[4*k +: 4];
  end
  return n;
endfunction

`endif

/* bench/alu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_tb import alu_pkg::*; ();

  // command plus ack, with room to spare
  localparam int ACK_TIMEOUT = 100;
  localparam int CMP_TIMEOUT = 8;

  logic                 clk;
  logic                 reset;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [WB_ADDR_W-1:0] wb_adr;
  logic [WB_DATA_W-1:0] wb_dat_w;
  logic [WB_DATA_W-1:0] wb_dat_r;
  logic                 wb_ack;

  int          seed;
  int          errors;
  int          snap_id;
  int          checked_id;
  logic [31:0] dut_halves [8];
  logic [31:0] dut_status;

  `include "alu_tb_ref.svh"

  saturn_alu_top u_saturn_alu_top (
    .i_clk    (clk),
    .i_reset  (reset),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_we  (wb_we),
    .i_wb_adr (wb_adr),
    .i_wb_dat (wb_dat_w),
    .o_wb_dat (wb_dat_r),
    .o_wb_ack (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  function automatic logic [31:0] make_cmd(alu_op_t op, reg_sel_t dest, src_sel_t src1,
                                           src_sel_t src2, logic [3:0] first,
                                           logic [3:0] last, nibble_t imm);
    logic [31:0] cmd;
    cmd = '0;
    cmd[CMD_OP_LSB +: CMD_OP_W]       = op;
    cmd[CMD_DEST_LSB +: CMD_DEST_W]   = dest;
    cmd[CMD_SRC1_LSB +: CMD_SRC1_W]   = src1;
    cmd[CMD_SRC2_LSB +: CMD_SRC2_W]   = src2;
    cmd[CMD_START_LSB +: CMD_START_W] = first;
    cmd[CMD_LAST_LSB +: CMD_LAST_W]   = last;
    cmd[CMD_IMM_LSB +: CMD_IMM_W]     = imm;
    return cmd;
  endfunction

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t ns: %s read %h, expected %h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // one classic cycle, held until ack
  task automatic wb_transfer(input logic we, input logic [WB_ADDR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int t;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    t = 0;
    @(negedge clk);
    while (!wb_ack && t < ACK_TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (!wb_ack) begin
      $display("no bus ack at address %0d within %0d cycles", adr, ACK_TIMEOUT);
      $display("TEST FAILED");
      $fatal(1, "bus timeout");
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_transfer(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [31:0] data);
    wb_transfer(1'b0, adr, '0, data);
  endtask

  task automatic load_half(input reg_sel_t sel, input logic half, input logic [31:0] data);
    wb_write(ADR_REG_BASE + 4'({sel, half}), data);
    ref_mirror.r[sel][half*32 +: 32] = data;
  endtask

  // reads everything back and hands it to the comparing process
  task automatic snapshot();
    int t;
    for (int i = 0; i < 8; i++)
      wb_read(ADR_REG_BASE + 4'(i), dut_halves[i]);
    wb_read(ADR_STATUS, dut_status);
    @(negedge clk);
    snap_id = snap_id + 1;
    t = 0;
    while (checked_id != snap_id && t < CMP_TIMEOUT) begin
      @(negedge clk);
      t++;
    end
    if (checked_id != snap_id) begin
      $display("comparison of snapshot %0d never ran", snap_id);
      $display("TEST FAILED");
      $fatal(1, "compare timeout");
    end
  endtask

  task automatic run_cmd(input logic [31:0] cmd);
    wb_write(ADR_CMD, cmd);
    ref_mirror = alu_ref(ref_mirror, cmd);
    snapshot();
  endtask

  // comparing process
  always @(posedge clk) begin
    if (checked_id != snap_id) begin
      for (int i = 0; i < 8; i++)
        check(dut_halves[i], ref_half(ref_mirror, 2'(i / 2), i[0]),
              $sformatf("reg %0d half %0d", i / 2, i % 2));
      check(dut_status, {31'b0, ref_mirror.carry}, "status");
      checked_id <= snap_id;
    end
  end

  initial begin
    seed       = 32'h487c8fe5;
    errors     = 0;
    snap_id    = 0;
    checked_id = 0;
    ref_mirror = '0;
    reset      = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // host access, status still clear from reset
    for (int i = 0; i < 8; i++)
      load_half(2'(i / 2), i[0], rnd());
    snapshot();

    // field writes, some wrapping past nibble 15
    run_cmd(make_cmd(OP_ZERO, 2'd0, 3'd0, 3'd0, 4'd3, 4'd7, 4'h0));
    run_cmd(make_cmd(OP_COPY, 2'd2, 3'd1, 3'd0, 4'd12, 4'd2, 4'h0));
    run_cmd(make_cmd(OP_COPY, 2'd3, SRC_IMM, 3'd0, 4'd5, 4'd9, 4'ha));
    run_cmd(make_cmd(OP_COPY, 2'd0, SRC_ZERO, 3'd0, 4'd14, 4'd14, 4'h0));
    run_cmd(make_cmd(OP_CLR_MASK, 2'd1, 3'd1, 3'd2, 4'd13, 4'd1, 4'h0));

    // full-width add that must carry out
    load_half(2'd0, 1'b0, 32'hffff_ffff);
    load_half(2'd0, 1'b1, 32'hffff_ffff);
    load_half(2'd1, 1'b0, 32'h0000_0001);
    load_half(2'd1, 1'b1, 32'h0000_0000);
    run_cmd(make_cmd(OP_ADD, 2'd2, 3'd0, 3'd1, 4'd0, 4'd15, 4'h0));
    for (int i = 0; i < 8; i++)
      load_half(2'(i / 2), i[0], rnd());
    for (int i = 0; i < 8; i++)
      run_cmd(make_cmd(OP_ADD, 2'(rnd()), 3'(rnd() % 4), 3'(rnd() % 6),
                       4'(rnd()), 4'(rnd()), 4'(rnd())));

    // swap and negate
    run_cmd(make_cmd(OP_EXCH, 2'd0, 3'd0, 3'd1, 4'd10, 4'd3, 4'h0));
    run_cmd(make_cmd(OP_2CMPL, 2'd3, 3'd2, 3'd0, 4'd0, 4'd7, 4'h0));
    run_cmd(make_cmd(OP_2CMPL, 2'd3, SRC_ZERO, 3'd0, 4'd4, 4'd11, 4'h0));

    // tests on equal and differing fields
    load_half(2'd2, 1'b0, 32'h1234_5678);
    load_half(2'd3, 1'b0, 32'h1234_5679);
    run_cmd(make_cmd(OP_TEST_EQ, 2'd0, 3'd1, 3'd1, 4'd0, 4'd15, 4'h0));
    run_cmd(make_cmd(OP_TEST_NEQ, 2'd0, 3'd1, 3'd1, 4'd0, 4'd15, 4'h0));
    run_cmd(make_cmd(OP_TEST_EQ, 2'd0, 3'd2, 3'd3, 4'd0, 4'd3, 4'h0));
    run_cmd(make_cmd(OP_TEST_NEQ, 2'd0, 3'd2, 3'd3, 4'd0, 4'd3, 4'h0));
    run_cmd(make_cmd(OP_TEST_EQ, 2'd0, 3'd2, 3'd3, 4'd1, 4'd7, 4'h0));

    // random command stream
    for (int i = 0; i < 40; i++)
      run_cmd(make_cmd(alu_op_t'(3'(rnd())), 2'(rnd()), 3'(rnd() % 6), 3'(rnd() % 6),
                       4'(rnd()), 4'(rnd()), 4'(rnd())));

    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
hdl/alu_pkg.sv
hdl/alu_seq_if.sv
hdl/alu_wb_slave.sv
hdl/alu_sequencer.sv
hdl/alu_regfile.sv
hdl/alu_nibble_unit.sv
hdl/saturn_alu_top.sv
bench/alu_tb.sv

/* hdl/alu_nibble_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_nibble_unit import alu_pkg::*; (
  input  logic        i_clk,
  input  logic        i_reset,
  input  nibble_t     i_src1_nib,
  input  nibble_t     i_src2_nib,
  output nibble_t     o_wr1_nib,
  output logic        o_wr1_en,
  output nibble_t     o_wr2_nib,
  output logic        o_wr2_en,
  output logic        o_carry,
  alu_seq_if.datapath seq
);

  nibble_t    p_src1;
  nibble_t    p_src2;
  logic       p_carry;
  nibble_t    c_res1;
  nibble_t    c_res2;
  logic       c_carry;
  nibble_t    res1_d;
  logic       carry_d;
  logic [4:0] sum;
  logic       is_test;

  assign is_test = (seq.op == OP_TEST_EQ) || (seq.op == OP_TEST_NEQ);

  // prep: operands and the incoming carry of the chain
  always_ff @(posedge i_clk) begin
    if (seq.prep) begin
      p_src1  <= i_src1_nib;
      p_src2  <= i_src2_nib;
      p_carry <= seq.first ? (seq.op == OP_2CMPL) : c_carry;
    end
  end

  always_comb begin
    sum     = {1'b0, p_src1} + {1'b0, p_src2} + {4'b0, p_carry};
    res1_d  = p_src1;
    carry_d = 1'b0;
    case (seq.op)
      OP_ZERO: res1_d = '0;
      OP_EXCH: res1_d = p_src2;
      OP_ADD:  {carry_d, res1_d} = sum;
      OP_2CMPL: begin
        res1_d = ~p_src1 + nibble_t'(p_carry);
        // carry survives only through zero digits
        carry_d = (p_src1 == '0) && p_carry;
      end
      OP_CLR_MASK: res1_d = p_src1 & ~p_src2;
      // tests chain a "some digit differs" flag
      OP_TEST_EQ, OP_TEST_NEQ: carry_d = (p_src1 != p_src2) || p_carry;
      default: ;
    endcase
  end

  // calc
  always_ff @(posedge i_clk) begin
    if (seq.calc) begin
      c_res1  <= res1_d;
      c_res2  <= p_src1;
      c_carry <= carry_d;
    end
  end

  // save
  assign o_wr1_nib = c_res1;
  assign o_wr2_nib = c_res2;
  assign o_wr1_en  = seq.save && !is_test;
  assign o_wr2_en  = seq.save && (seq.op == OP_EXCH) && !seq.src2[2];

  // CARRY flag, settled on the last save
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_carry <= 1'b0;
    end else if (seq.save && seq.last) begin
      case (seq.op)
        OP_ADD:      o_carry <= c_carry;
        // chain ends high only for an all-zero field
        OP_2CMPL:    o_carry <= !c_carry;
        OP_TEST_EQ:  o_carry <= !c_carry;
        OP_TEST_NEQ: o_carry <= c_carry;
        default:     o_carry <= o_carry;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  localparam int NIBBLES   = 16;
  localparam int WB_ADDR_W = 4;
  localparam int WB_DATA_W = 32;
  // nibbles in one 32-bit register half
  localparam int HALF_NIBS = WB_DATA_W / 4;

  typedef logic [3:0] nibble_t;
  typedef logic [$clog2(NIBBLES)-1:0] nib_idx_t;
  typedef logic [1:0] reg_sel_t;
  typedef logic [2:0] src_sel_t;

  // source codes 0 to 3 pick A to D directly
  localparam src_sel_t SRC_IMM  = 3'd4;
  localparam src_sel_t SRC_ZERO = 3'd5;

  typedef enum logic [2:0] {
    OP_ZERO,
    OP_COPY,
    OP_EXCH,
    OP_ADD,
    OP_2CMPL,
    OP_CLR_MASK,
    OP_TEST_EQ,
    OP_TEST_NEQ
  } alu_op_t;

  // wishbone address map
  localparam logic [WB_ADDR_W-1:0] ADR_CMD      = 4'd0;
  localparam logic [WB_ADDR_W-1:0] ADR_STATUS   = 4'd1;
  localparam logic [WB_ADDR_W-1:0] ADR_REG_BASE = 4'd8;

  // command word layout
  localparam int CMD_OP_LSB    = 0;
  localparam int CMD_OP_W      = 3;
  localparam int CMD_DEST_LSB  = 4;
  localparam int CMD_DEST_W    = 2;
  localparam int CMD_SRC1_LSB  = 8;
  localparam int CMD_SRC1_W    = 3;
  localparam int CMD_SRC2_LSB  = 12;
  localparam int CMD_SRC2_W    = 3;
  localparam int CMD_START_LSB = 16;
  localparam int CMD_START_W   = 4;
  localparam int CMD_LAST_LSB  = 20;
  localparam int CMD_LAST_W    = 4;
  localparam int CMD_IMM_LSB   = 24;
  localparam int CMD_IMM_W     = 4;

endpackage

`default_nettype wire

/* hdl/alu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_regfile import alu_pkg::*; (
  input  logic                 i_clk,
  input  nibble_t              i_wr1_nib,
  input  logic                 i_wr1_en,
  input  nibble_t              i_wr2_nib,
  input  logic                 i_wr2_en,
  input  reg_sel_t             i_host_sel,
  input  logic                 i_host_half,
  input  logic [WB_DATA_W-1:0] i_host_wdata,
  input  logic                 i_host_we,
  output nibble_t              o_src1_nib,
  output nibble_t              o_src2_nib,
  output logic [WB_DATA_W-1:0] o_host_rdata,
  alu_seq_if.datapath          seq
);

  // A, B, C, D as nibble arrays
  nibble_t regs [4][NIBBLES];

  function automatic nibble_t operand(src_sel_t sel, nibble_t reg_nib, nibble_t imm);
    case (sel)
      SRC_IMM:  return imm;
      SRC_ZERO: return '0;
      default:  return reg_nib;
    endcase
  endfunction

  assign o_src1_nib = operand(seq.src1, regs[seq.src1[1:0]][seq.cur], seq.imm);
  assign o_src2_nib = operand(seq.src2, regs[seq.src2[1:0]][seq.cur], seq.imm);

  // host view, half 0 holds nibbles 0 to 7
  always_comb begin
    for (int i = 0; i < HALF_NIBS; i++)
      o_host_rdata[4*i +: 4] = regs[i_host_sel][nib_idx_t'(i_host_half * HALF_NIBS + i)];
  end

  always_ff @(posedge i_clk) begin
    if (i_host_we) begin
      for (int i = 0; i < HALF_NIBS; i++)
        regs[i_host_sel][nib_idx_t'(i_host_half * HALF_NIBS + i)] <= i_host_wdata[4*i +: 4];
    end
    if (i_wr1_en)
      regs[seq.dest][seq.cur] <= i_wr1_nib;
    // second port last, so src2 wins if it names dest too
    if (i_wr2_en)
      regs[seq.src2[1:0]][seq.cur] <= i_wr2_nib;
  end

  // host writes are held off while a command runs
  assert property (@(posedge i_clk) !(i_host_we && seq.save));

endmodule

`default_nettype wire

/* hdl/alu_seq_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface alu_seq_if import alu_pkg::*; ();

  // phase strobes, one per cycle while a command runs
  logic     prep;
  logic     calc;
  logic     save;

  // current nibble and its position in the field
  nib_idx_t cur;
  logic     first;
  logic     last;

  // command as latched at start
  alu_op_t  op;
  reg_sel_t dest;
  src_sel_t src1;
  src_sel_t src2;
  nibble_t  imm;

  modport sequencer (
    output prep, calc, save, cur, first, last, op, dest, src1, src2, imm
  );

  modport datapath (
    input prep, calc, save, cur, first, last, op, dest, src1, src2, imm
  );

endinterface

`default_nettype wire

/* hdl/alu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_sequencer import alu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_start,
  input  logic [WB_DATA_W-1:0] i_cmd,
  output logic                 o_done,
  alu_seq_if.sequencer         seq
);

  nib_idx_t first_idx;
  nib_idx_t last_idx;
  logic     running;

  assign seq.first = (seq.cur == first_idx);
  assign seq.last  = (seq.cur == last_idx);

  // command fields and field pointer
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      seq.op    <= alu_op_t'(i_cmd[CMD_OP_LSB +: CMD_OP_W]);
      seq.dest  <= i_cmd[CMD_DEST_LSB +: CMD_DEST_W];
      seq.src1  <= i_cmd[CMD_SRC1_LSB +: CMD_SRC1_W];
      seq.src2  <= i_cmd[CMD_SRC2_LSB +: CMD_SRC2_W];
      seq.imm   <= i_cmd[CMD_IMM_LSB +: CMD_IMM_W];
      first_idx <= i_cmd[CMD_START_LSB +: CMD_START_W];
      last_idx  <= i_cmd[CMD_LAST_LSB +: CMD_LAST_W];
      seq.cur   <= i_cmd[CMD_START_LSB +: CMD_START_W];
    end else if (seq.save) begin
      // wraps modulo 16
      seq.cur <= seq.cur + 1'b1;
    end
  end

  // prep -> calc -> save ring, restarted per nibble until the last one
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      running  <= 1'b0;
      seq.prep <= 1'b0;
      seq.calc <= 1'b0;
      seq.save <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      seq.prep <= i_start || (seq.save && !seq.last);
      seq.calc <= seq.prep;
      seq.save <= seq.calc;
      o_done   <= seq.save && seq.last;
      if (i_start)
        running <= 1'b1;
      else if (seq.save && seq.last)
        running <= 1'b0;
    end
  end

  assert property (@(posedge i_clk) disable iff (i_reset)
    running |-> $onehot({seq.prep, seq.calc, seq.save}));

  assert property (@(posedge i_clk) disable iff (i_reset)
    !running |-> !(seq.prep || seq.calc || seq.save));

endmodule

`default_nettype wire

/* hdl/alu_wb_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_wb_slave import alu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  logic                 i_wb_we,
  input  logic [WB_ADDR_W-1:0] i_wb_adr,
  input  logic [WB_DATA_W-1:0] i_wb_dat,
  input  logic                 i_done,
  input  logic                 i_carry,
  input  logic [WB_DATA_W-1:0] i_host_rdata,
  output logic [WB_DATA_W-1:0] o_wb_dat,
  output logic                 o_wb_ack,
  output logic                 o_start,
  output logic [WB_DATA_W-1:0] o_cmd,
  output reg_sel_t             o_host_sel,
  output logic                 o_host_half,
  output logic [WB_DATA_W-1:0] o_host_wdata,
  output logic                 o_host_we
);

  logic       busy;
  logic       req;
  logic       is_cmd;
  logic       is_reg;
  logic [2:0] reg_off;

  // a new transfer, not yet answered and not behind a running command
  assign req     = i_wb_cyc && i_wb_stb && !busy && !o_wb_ack;
  assign is_cmd  = i_wb_we && (i_wb_adr == ADR_CMD);
  assign is_reg  = (i_wb_adr >= ADR_REG_BASE);
  assign reg_off = 3'(i_wb_adr - ADR_REG_BASE);

  // register half select: 8 + 2*reg + half
  assign o_host_sel   = reg_off[2:1];
  assign o_host_half  = reg_off[0];
  assign o_host_wdata = i_wb_dat;
  assign o_host_we    = req && i_wb_we && is_reg;

  assign o_start = req && is_cmd;
  assign o_cmd   = i_wb_dat;

  // ack and busy tracking
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_wb_ack <= 1'b0;
      busy     <= 1'b0;
    end else begin
      o_wb_ack <= 1'b0;
      if (i_done) begin
        busy     <= 1'b0;
        o_wb_ack <= 1'b1;
      end else if (o_start) begin
        busy <= 1'b1;
      end else if (req) begin
        // status and register halves answer right away
        o_wb_ack <= 1'b1;
      end
    end
  end

  // read data, captured with the request
  always_ff @(posedge i_clk) begin
    if (req) begin
      if (is_reg)
        o_wb_dat <= i_host_rdata;
      else if (i_wb_adr == ADR_STATUS)
        o_wb_dat <= {{(WB_DATA_W-1){1'b0}}, i_carry};
      else
        o_wb_dat <= '0;
    end
  end

  // ack only answers a held strobe
  assert property (@(posedge i_clk) disable iff (i_reset)
    o_wb_ack |-> (i_wb_cyc && i_wb_stb));

  // the sequencer only finishes what was launched here
  assert property (@(posedge i_clk) disable iff (i_reset)
    i_done |-> busy);

endmodule

`default_nettype wire

/* hdl/saturn_alu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module saturn_alu_top import alu_pkg::*; (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  logic                 i_wb_we,
  input  logic [WB_ADDR_W-1:0] i_wb_adr,
  input  logic [WB_DATA_W-1:0] i_wb_dat,
  output logic [WB_DATA_W-1:0] o_wb_dat,
  output logic                 o_wb_ack
);

  logic                 start;
  logic [WB_DATA_W-1:0] cmd;
  logic                 done;
  logic                 carry;
  reg_sel_t             host_sel;
  logic                 host_half;
  logic [WB_DATA_W-1:0] host_wdata;
  logic                 host_we;
  logic [WB_DATA_W-1:0] host_rdata;
  nibble_t              src1_nib;
  nibble_t              src2_nib;
  nibble_t              wr1_nib;
  logic                 wr1_en;
  nibble_t              wr2_nib;
  logic                 wr2_en;

  alu_seq_if u_seq_if ();

  alu_wb_slave u_wb_slave (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_wb_cyc     (i_wb_cyc),
    .i_wb_stb     (i_wb_stb),
    .i_wb_we      (i_wb_we),
    .i_wb_adr     (i_wb_adr),
    .i_wb_dat     (i_wb_dat),
    .i_done       (done),
    .i_carry      (carry),
    .i_host_rdata (host_rdata),
    .o_wb_dat     (o_wb_dat),
    .o_wb_ack     (o_wb_ack),
    .o_start      (start),
    .o_cmd        (cmd),
    .o_host_sel   (host_sel),
    .o_host_half  (host_half),
    .o_host_wdata (host_wdata),
    .o_host_we    (host_we)
  );

  alu_sequencer u_sequencer (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_start (start),
    .i_cmd   (cmd),
    .o_done  (done),
    .seq     (u_seq_if)
  );

  alu_regfile u_regfile (
    .i_clk        (i_clk),
    .i_wr1_nib    (wr1_nib),
    .i_wr1_en     (wr1_en),
    .i_wr2_nib    (wr2_nib),
    .i_wr2_en     (wr2_en),
    .i_host_sel   (host_sel),
    .i_host_half  (host_half),
    .i_host_wdata (host_wdata),
    .i_host_we    (host_we),
    .o_src1_nib   (src1_nib),
    .o_src2_nib   (src2_nib),
    .o_host_rdata (host_rdata),
    .seq          (u_seq_if)
  );

  alu_nibble_unit u_nibble_unit (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_src1_nib (src1_nib),
    .i_src2_nib (src2_nib),
    .o_wr1_nib  (wr1_nib),
    .o_wr1_en   (wr1_en),
    .o_wr2_nib  (wr2_nib),
    .o_wr2_en   (wr2_en),
    .o_carry    (carry),
    .seq        (u_seq_if)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module alu_tb -o alu_tb_sim
./obj_dir/alu_tb_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
